//--- spiMilBridge.f
rtl/milStd1553Pkg.sv
rtl/spiProtoPkg.sv
rtl/spiWordIf.sv
rtl/spiWordReceiver.sv
rtl/frameParser.sv
rtl/wordFifo.sv
rtl/milBitTimer.sv
rtl/milEncoder.sv
rtl/milDecoder.sv
rtl/spiMilBridge.sv
testbench/spiMilBridge_props.sv
testbench/spiMilBridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -Wno-fatal
TOP       ?= spiMilBridge_tb
FILELIST  ?= spiMilBridge.f
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the result"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- testbench/spiMilBridge_tb.sv
`timescale 1ns/100ps
`default_nettype none

module spiMilBridge_tb;

	localparam logic [7:0] blockAddr     = 8'hAB;
	localparam logic [7:0] sendCmd       = 8'hA2;
	localparam int         clkPerHalfBit = 5;
	localparam int         parityStart   = 38 * clkPerHalfBit; // first cycle of the parity bit
	localparam int         numRows       = 16;
	localparam int         rxTimeout     = 2000;
	localparam int         quietCycles   = 1000;

	typedef struct packed {
		logic [7:0]  frameId;
		logic [7:0]  addr;
		logic [7:0]  cmd;
		logic        isCommand;
		logic [15:0] data;
		logic        badSum;
		logic        badParity;
	} stimRow_t;

	logic        clk;
	logic        rstN;
	logic        spiSclk;
	logic        spiMosi;
	logic        spiCsN;
	logic        rxPop;
	logic        milTx;
	logic        milTxN;
	logic        milRx;
	logic        milRxN;
	logic        rxReady;
	logic [15:0] rxData;
	logic        rxIsCommand;
	logic        rxParityErr;
	logic        frameErr;
	logic        flipNow;

	stimRow_t    stim [numRows];
	logic [15:0] spiWords[$];
	logic [15:0] lfsrState = 16'd17104;
	int          activeCnt = 0;
	int          wordsStarted = 0;
	int          flipIndex = -1; // transmitted word whose parity gets inverted
	int          txCount = 0;
	int          errPulses = 0;
	int          expErrPulses = 0;

	spiMilBridge #(.blockAddr(blockAddr), .clkPerHalfBit(clkPerHalfBit), .fifoDepth(16)) u_dut (
		.clk(clk), .rstN(rstN), .spiSclk(spiSclk), .spiMosi(spiMosi), .spiCsN(spiCsN),
		.milTx(milTx), .milTxN(milTxN), .milRx(milRx), .milRxN(milRxN), .rxPop(rxPop),
		.rxReady(rxReady), .rxData(rxData), .rxIsCommand(rxIsCommand),
		.rxParityErr(rxParityErr), .frameErr(frameErr));

	always #50 clk = ~clk;

	// loopback, optionally inverting both parity halves of one word
	assign flipNow = (milTx | milTxN) && flipIndex >= 0 && wordsStarted == flipIndex + 1
		&& activeCnt >= parityStart;
	assign milRx   = milTx ^ flipNow;
	assign milRxN  = milTxN ^ flipNow;

	always @(posedge clk)
	begin
		if (milTx | milTxN)
		begin
			if (activeCnt == 0)
				wordsStarted <= wordsStarted + 1;
			activeCnt <= activeCnt + 1; // cycle index inside the word
		end
		else
			activeCnt <= 0;
		if (rstN && frameErr)
			errPulses <= errPulses + 1;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("ERROR %s: expected %0h, actual %0h", testName, expected, actual));
	endtask

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState); // one step per bit
			value     = {value[14:0], lfsrState[0]};
		end
	endtask

	task automatic setRow(input int idx, input logic [7:0] fid, input logic [7:0] addr,
		input logic [7:0] cmd, input logic isCmd, input logic [15:0] data,
		input logic badSum, input logic badPar);
		stim[idx] = {fid, addr, cmd, isCmd, data, badSum, badPar};
	endtask

	task automatic fillTable();
		logic [15:0] cmdBit;
		logic [15:0] data;
		setRow(0, 1, blockAddr, sendCmd, 1, 16'h0C21, 0, 0); // mixed command and data
		setRow(1, 1, blockAddr, sendCmd, 0, 16'h1234, 0, 0);
		setRow(2, 1, blockAddr, sendCmd, 0, 16'hBEEF, 0, 0);
		setRow(3, 2, blockAddr, sendCmd, 0, 16'hFFA1, 0, 0); // literal markers
		setRow(4, 2, blockAddr, sendCmd, 0, 16'hFFA3, 0, 0);
		setRow(5, 2, blockAddr, sendCmd, 1, 16'h4422, 0, 0);
		setRow(6, 3, 8'h5C, sendCmd, 0, 16'h1111, 0, 0); // other block
		setRow(7, 4, blockAddr, 8'hB2, 0, 16'h2222, 0, 0); // unsupported command
		setRow(8, 5, blockAddr, sendCmd, 0, 16'h5A5A, 1, 0); // wrong checksum
		setRow(9, 5, blockAddr, sendCmd, 1, 16'h0841, 0, 0);
		setRow(10, 6, blockAddr, sendCmd, 0, 16'h3C3C, 0, 1); // parity inverted on the line
		setRow(11, 6, blockAddr, sendCmd, 0, 16'h00FF, 0, 0);
		for (int i = 12; i < numRows; i++)
		begin
			takeBits(1, cmdBit);
			takeBits(16, data);
			setRow(i, 7, blockAddr, sendCmd, cmdBit[0], data, 0, 0);
		end
	endtask

	// mode 0, msb first, 8 clk per sclk period
	task automatic sendSpiFrame();
		spiCsN <= 1'b0;
		repeat (8) @(posedge clk);
		foreach (spiWords[w])
		begin
			for (int b = 15; b >= 0; b--)
			begin
				spiMosi <= spiWords[w][b];
				repeat (4) @(posedge clk);
				spiSclk <= 1'b1;
				repeat (4) @(posedge clk);
				spiSclk <= 1'b0;
			end
		end
		repeat (8) @(posedge clk);
		spiCsN <= 1'b1;
		repeat (8) @(posedge clk);
	endtask

	task automatic popRxWord(output logic [17:0] got);
		int waited;
		waited = 0;
		@(posedge clk);
		while (!rxReady && waited < rxTimeout)
		begin
			@(posedge clk);
			waited++;
		end
		if (!rxReady)
			failRun("timeout: no word came back through the loopback");
		got = {rxIsCommand, rxData, rxParityErr};
		rxPop <= 1'b1;
		@(posedge clk);
		rxPop <= 1'b0;
	endtask

	task automatic expectSilence(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge clk);
			if (rxReady)
				failRun("a word was received from a frame that should have been ignored");
		end
	endtask

	task automatic runFrame(input int first, input int last);
		logic [15:0] payload[$];
		logic [15:0] sum;
		logic        accepted;
		logic        badSum;
		logic [17:0] got;
		int          expRows[$];
		accepted = (stim[first].addr == blockAddr) && (stim[first].cmd == sendCmd);
		badSum   = 1'b0;
		for (int i = first; i < last; i++)
		begin
			if (stim[i].isCommand)
				payload.push_back(16'hFFA1);
			else if (stim[i].data == 16'hFFA1 || stim[i].data == 16'hFFA3)
				payload.push_back(16'hFFA3);
			payload.push_back(stim[i].data);
			badSum = badSum | stim[i].badSum;
			if (accepted)
			begin
				if (stim[i].badParity)
					flipIndex = txCount;
				expRows.push_back(i);
				txCount++;
			end
		end
		spiWords.delete();
		spiWords.push_back({stim[first].addr, 8'h00});
		spiWords.push_back({8'(payload.size()), stim[first].cmd});
		foreach (payload[j])
			spiWords.push_back(payload[j]);
		sum = '0;
		foreach (spiWords[j])
			sum = sum + spiWords[j]; // header included
		spiWords.push_back(badSum ? ~sum : sum);
		spiWords.push_back({8'h00, stim[first].frameId}); // sequence word
		sendSpiFrame();
		if (accepted && badSum)
			expErrPulses++;
		if (accepted)
		begin
			foreach (expRows[k])
			begin
				popRxWord(got);
				checkValue($sformatf("row %0d isCommand", expRows[k]),
					stim[expRows[k]].isCommand, got[17]);
				checkValue($sformatf("row %0d data", expRows[k]), stim[expRows[k]].data,
					got[16:1]);
				checkValue($sformatf("row %0d parityErr", expRows[k]),
					stim[expRows[k]].badParity, got[0]);
			end
		end
		else
			expectSilence(quietCycles);
		checkValue($sformatf("frame %0d frameErr pulses", stim[first].frameId),
			expErrPulses, errPulses);
	endtask

	initial
	begin
		int first;
		int last;
		clk     = 1'b0;
		rstN    = 1'b0;
		spiSclk = 1'b0;
		spiMosi = 1'b0;
		spiCsN  = 1'b1;
		rxPop   = 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);
		checkValue("reset milTx", 0, milTx);
		checkValue("reset milTxN", 0, milTxN);
		checkValue("reset rxReady", 0, rxReady);
		checkValue("reset frameErr", 0, frameErr);
		fillTable();
		first = 0;
		while (first < numRows)
		begin
			last = first + 1;
			while (last < numRows && stim[last].frameId == stim[first].frameId)
				last++;
			runFrame(first, last);
			first = last;
		end
		expectSilence(quietCycles); // nothing left over
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/spiMilBridge_props.sv
`timescale 1ns/100ps
`default_nettype none

module spiMilBridge_props import milStd1553Pkg::*; #(
	parameter int clkPerHalfBit = 5
) (
	input logic clk,
	input logic rstN,
	input logic txPop,
	input logic milTx,
	input logic milTxN
);

	localparam int wordCycles = milWordHalves * clkPerHalfBit;
	localparam int gapCycles  = milGapBits * 2 * clkPerHalfBit;

	int activeLen; // cycles with exactly one line high
	int idleLen;   // cycles with both lines low

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			activeLen <= 0;
			idleLen   <= gapCycles; // no earlier word to keep apart from
		end
		else
		begin
			activeLen <= (milTx != milTxN) ? activeLen + 1 : 0;
			if (milTx || milTxN)
				idleLen <= 0;
			else if (idleLen < gapCycles)
				idleLen <= idleLen + 1;
		end
	end

	// differential pair, one line high for a whole word and never both
	assert property (@(posedge clk) disable iff (!rstN)
		$fell(milTx || milTxN) |-> activeLen == wordCycles)
		else $error("line was not driven differentially for exactly one word time");

	assert property (@(posedge clk) disable iff (!rstN) txPop |-> idleLen >= gapCycles)
		else $error("txPop asserted before both lines were low for the whole gap");

	assert property (@(posedge clk) disable iff (!rstN) txPop |=> (milTx != milTxN))
		else $error("no word started on the line after txPop");

endmodule

bind milEncoder spiMilBridge_props #(.clkPerHalfBit(clkPerHalfBit)) encoderProps (.clk(clk),
	.rstN(rstN), .txPop(txPop), .milTx(milTx), .milTxN(milTxN));

`default_nettype wire

//--- rtl/spiMilBridge.sv
`timescale 1ns/100ps
`default_nettype none

module spiMilBridge import milStd1553Pkg::*; #(
	parameter logic [7:0] blockAddr     = 8'hAB,
	parameter int         clkPerHalfBit = 5,  // 1 Mbit/s at 10 MHz
	parameter int         fifoDepth     = 16
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        spiSclk,
	input  logic        spiMosi,
	input  logic        spiCsN,
	output logic        milTx,
	output logic        milTxN,
	input  logic        milRx,
	input  logic        milRxN,
	input  logic        rxPop,
	output logic        rxReady,
	output logic [15:0] rxData,
	output logic        rxIsCommand,
	output logic        rxParityErr,
	output logic        frameErr
);

	spiWordIf   wordBus ();
	milWord_t   txPushWord;
	milWord_t   txHead;
	milRxWord_t rxPushWord;
	milRxWord_t rxHead;
	logic       txPush;
	logic       txFull;
	logic       txEmpty;
	logic       txPop;
	logic       rxPush;
	logic       rxEmpty;

	spiWordReceiver spiRx (.clk(clk), .rstN(rstN), .spiSclk(spiSclk), .spiMosi(spiMosi),
		.spiCsN(spiCsN), .wordBus(wordBus));

	frameParser #(.blockAddr(blockAddr)) parser (.clk(clk), .rstN(rstN), .wordBus(wordBus),
		.fifoPush(txPush), .fifoWord(txPushWord), .fifoFull(txFull), .frameErr(frameErr));

	wordFifo #(.payload_t(milWord_t), .fifoDepth(fifoDepth)) txFifo (.clk(clk), .rstN(rstN),
		.push(txPush), .pushData(txPushWord), .pop(txPop), .popData(txHead),
		.empty(txEmpty), .full(txFull));

	milEncoder #(.clkPerHalfBit(clkPerHalfBit)) encoder (.clk(clk), .rstN(rstN),
		.txWord(txHead), .txAvail(~txEmpty), .txPop(txPop), .milTx(milTx), .milTxN(milTxN));

	milDecoder #(.clkPerHalfBit(clkPerHalfBit)) decoder (.clk(clk), .rstN(rstN),
		.milRx(milRx), .milRxN(milRxN), .rxPush(rxPush), .rxWord(rxPushWord));

	// new words are dropped while full
	wordFifo #(.payload_t(milRxWord_t), .fifoDepth(fifoDepth)) rxFifo (.clk(clk), .rstN(rstN),
		.push(rxPush), .pushData(rxPushWord), .pop(rxPop), .popData(rxHead),
		.empty(rxEmpty), .full());

	assign rxReady     = ~rxEmpty;
	assign rxData      = rxHead.data;
	assign rxIsCommand = rxHead.isCommand;
	assign rxParityErr = rxHead.parityErr;

endmodule

`default_nettype wire

//--- rtl/milDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module milDecoder import milStd1553Pkg::*; #(
	parameter int clkPerHalfBit = 5
) (
	input  logic       clk,
	input  logic       rstN,
	input  logic       milRx,
	input  logic       milRxN,
	output logic       rxPush,
	output milRxWord_t rxWord
);

	localparam int syncMin  = (milSyncHalfBits - 1) * clkPerHalfBit;
	localparam int syncMax  = (milSyncHalfBits + 1) * clkPerHalfBit;
	localparam int syncBits = $clog2(syncMax + 1);
	localparam int lastHalf = milWordHalves - milSyncHalfBits - 1; // parity second half

	typedef enum logic [1:0] {idle, syncFirst, bits, flush} state_t;

	state_t                 state;
	logic [1:0]             rxSync;
	logic [1:0]             rxNSync;
	logic                   lineValid;
	logic                   level;
	logic                   firstLevel; // high first means command sync
	logic [syncBits-1:0]    syncCnt;
	logic [5:0]             halfIdx;
	logic [5:0]             dataHalf;
	logic                   firstHalf;
	logic [milDataBits-1:0] bitShift;
	logic                   restart;
	logic                   midTick;

	assign lineValid = rxSync[1] ^ rxNSync[1]; // both low is idle
	assign level     = rxSync[1];
	assign restart   = (state == syncFirst) && lineValid && (level != firstLevel);
	assign dataHalf  = halfIdx - 6'(milSyncHalfBits);

	milBitTimer #(.clkPerHalfBit(clkPerHalfBit)) bitTimer (
		.clk     (clk),
		.rstN    (rstN),
		.restart (restart), // sync mid-edge
		.halfTick(),
		.midTick (midTick)
	);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state   <= idle;
			rxSync  <= '0;
			rxNSync <= '0;
			syncCnt <= '0;
			halfIdx <= '0;
			rxPush  <= 1'b0;
		end
		else
		begin
			rxSync  <= {rxSync[0], milRx};
			rxNSync <= {rxNSync[0], milRxN};
			rxPush  <= 1'b0;
			case (state)
				idle:
					if (lineValid)
					begin
						state   <= syncFirst;
						syncCnt <= syncBits'(1);
					end
				syncFirst:
					if (!lineValid)
						state <= idle;
					else if (restart)
					begin
						halfIdx <= '0;
						if (syncCnt > syncBits'(syncMin) && syncCnt < syncBits'(syncMax))
							state <= bits;
						else
							state <= flush; // not a sync
					end
					else if (syncCnt == syncBits'(syncMax))
						state <= flush;
					else
						syncCnt <= syncCnt + 1'b1;
				bits:
					if (midTick)
					begin
						halfIdx <= halfIdx + 1'b1;
						if (!lineValid)
							state <= flush;
						else if (halfIdx < 6'(milSyncHalfBits))
						begin
							if (level == firstLevel)
								state <= flush; // second sync half wrong
						end
						else if (dataHalf[0])
						begin
							if (level == firstHalf)
								state <= flush; // missing mid-bit transition
							else if (halfIdx == 6'(lastHalf))
							begin
								rxPush <= 1'b1;
								state  <= flush;
							end
						end
					end
				default:
					if (!lineValid)
						state <= idle; // wait for the line to go idle
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == idle)
			firstLevel <= level;
		if (state == bits && midTick && halfIdx >= 6'(milSyncHalfBits))
		begin
			if (!dataHalf[0])
				firstHalf <= level;
			else
				bitShift <= {bitShift[milDataBits-2:0], firstHalf};
			if (halfIdx == 6'(lastHalf))
			begin
				rxWord.isCommand <= firstLevel;
				rxWord.data      <= bitShift;
				rxWord.parityErr <= ~^{bitShift, firstHalf}; // odd parity expected
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/milEncoder.sv
`timescale 1ns/100ps
`default_nettype none

module milEncoder import milStd1553Pkg::*; #(
	parameter int clkPerHalfBit = 5
) (
	input  logic     clk,
	input  logic     rstN,
	input  milWord_t txWord,
	input  logic     txAvail,
	output logic     txPop,
	output logic     milTx,
	output logic     milTxN
);

	localparam int gapCycles = milGapBits * 2 * clkPerHalfBit;
	localparam int gapBits   = $clog2(gapCycles + 1);

	logic                        busy;
	logic [milWordHalves-1:0]    pattern; // msb is the current half
	logic [$clog2(milWordHalves)-1:0] halfCnt;
	logic [gapBits-1:0]          gapCnt;
	logic                        gapDone;
	logic                        halfTick;

	function automatic logic [milWordHalves-1:0] buildPattern(input milWord_t w);
		logic [milWordHalves-1:0] p;
		logic                     parity;
		parity = ~^w.data; // odd parity
		p      = '0;
		if (w.isCommand)
			p[milWordHalves-1 -: 2*milSyncHalfBits] = {{milSyncHalfBits{1'b1}},
				{milSyncHalfBits{1'b0}}};
		else
			p[milWordHalves-1 -: 2*milSyncHalfBits] = {{milSyncHalfBits{1'b0}},
				{milSyncHalfBits{1'b1}}};
		for (int i = 0; i < milDataBits; i++)
			p[2*i+3 -: 2] = {w.data[i], ~w.data[i]}; // one is high then low
		p[1:0] = {parity, ~parity};
		return p;
	endfunction

	milBitTimer #(.clkPerHalfBit(clkPerHalfBit)) bitTimer (
		.clk     (clk),
		.rstN    (rstN),
		.restart (txPop),
		.halfTick(halfTick),
		.midTick ()
	);

	assign gapDone = (gapCnt == gapBits'(gapCycles));
	assign txPop   = ~busy & txAvail & gapDone;
	assign milTx   = busy & pattern[milWordHalves-1];
	assign milTxN  = busy & ~pattern[milWordHalves-1];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy    <= 1'b0;
			halfCnt <= '0;
			gapCnt  <= gapBits'(gapCycles); // first word may go at once
		end
		else if (txPop)
		begin
			busy    <= 1'b1;
			halfCnt <= '0;
			gapCnt  <= '0;
		end
		else if (busy)
		begin
			if (halfTick)
			begin
				halfCnt <= halfCnt + 1'b1;
				if (halfCnt == $bits(halfCnt)'(milWordHalves - 1))
					busy <= 1'b0;
			end
		end
		else if (!gapDone)
			gapCnt <= gapCnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (txPop)
			pattern <= buildPattern(txWord);
		else if (busy && halfTick)
			pattern <= pattern << 1;
	end

endmodule

`default_nettype wire

//--- rtl/milBitTimer.sv
`timescale 1ns/100ps
`default_nettype none

module milBitTimer #(
	parameter int clkPerHalfBit = 5
) (
	input  logic clk,
	input  logic rstN,
	input  logic restart,
	output logic halfTick,
	output logic midTick
);

	localparam int                cntBits = (clkPerHalfBit > 1) ? $clog2(clkPerHalfBit) : 1;
	localparam logic [cntBits-1:0] lastCnt = cntBits'(clkPerHalfBit - 1);
	localparam logic [cntBits-1:0] midCnt  = cntBits'((clkPerHalfBit - 1) / 2);

	logic [cntBits-1:0] cnt;

	always_ff @(posedge clk)
	begin
		if (!rstN || restart)
			cnt <= '0;
		else if (cnt == lastCnt)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// no ticks from the stale count while reloading
	assign halfTick = ~restart & (cnt == lastCnt);
	assign midTick  = ~restart & (cnt == midCnt);

endmodule

`default_nettype wire

//--- rtl/wordFifo.sv
`timescale 1ns/100ps
`default_nettype none

module wordFifo #(
	parameter type payload_t = logic [15:0],
	parameter int  fifoDepth = 16
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     push,
	input  payload_t pushData,
	input  logic     pop,
	output payload_t popData,
	output logic     empty,
	output logic     full
);

	localparam int ptrBits = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

	payload_t           mem [fifoDepth];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [ptrBits:0]   fill;
	logic               doPush;
	logic               doPop;

	function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
		return (ptr == ptrBits'(fifoDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign doPush  = push & ~full; // writes into a full FIFO are lost
	assign doPop   = pop & ~empty;
	assign empty   = (fill == '0);
	assign full    = (fill == (ptrBits + 1)'(fifoDepth));
	assign popData = mem[rdPtr]; // head word

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill  <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			fill <= fill + doPush - doPop;
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

`default_nettype wire

//--- rtl/frameParser.sv
`timescale 1ns/100ps
`default_nettype none

module frameParser import spiProtoPkg::*; import milStd1553Pkg::*; #(
	parameter logic [7:0] blockAddr = 8'hAB
) (
	input  logic     clk,
	input  logic     rstN,
	spiWordIf.dst    wordBus,
	output logic     fifoPush,
	output milWord_t fifoWord,
	input  logic     fifoFull,
	output logic     frameErr
);

	typedef enum logic [2:0] {
		idle, header, sizeCmd, payload, escaped, checksum, trailer, skip
	} state_t;

	state_t       state;
	logic [7:0]   remain;   // payload words still expected
	logic         escCmd;   // marker seen was FFA1
	logic [15:0]  sumAcc;
	addrWord_t    addrWord;
	sizeCmdWord_t sizeWord;
	logic         isMarker;

	assign addrWord = wordBus.word;
	assign sizeWord = wordBus.word;
	assign isMarker = (wordBus.word == escCommand) || (wordBus.word == escData);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state    <= idle;
			remain   <= '0;
			escCmd   <= 1'b0;
			sumAcc   <= '0;
			fifoPush <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			fifoPush <= 1'b0;
			frameErr <= fifoPush & fifoFull; // overflow, word was dropped
			if (wordBus.frameStart)
			begin
				state  <= header;
				sumAcc <= '0;
			end
			else if (wordBus.frameEnd)
			begin
				state <= idle;
				if (state inside {payload, escaped, checksum})
					frameErr <= 1'b1; // truncated frame
			end
			else if (wordBus.wordValid)
			begin
				sumAcc <= sumAcc + wordBus.word;
				case (state)
					header:
						if (addrWord.addr == blockAddr && addrWord.reserved == hdrReserved)
							state <= sizeCmd;
						else
							state <= skip; // other block
					sizeCmd:
						if (sizeWord.cmd != cmdSendMil)
							state <= skip;
						else
						begin
							remain <= sizeWord.count;
							state  <= (sizeWord.count == 8'd0) ? checksum : payload;
						end
					payload, escaped:
					begin
						remain <= remain - 1'b1;
						if (state == payload && isMarker)
							escCmd <= (wordBus.word == escCommand);
						else
							fifoPush <= 1'b1;
						if (remain == 8'd1)
							state <= checksum;
						else if (state == payload && isMarker)
							state <= escaped;
						else
							state <= payload;
					end
					checksum:
					begin
						if (wordBus.word != sumAcc)
							frameErr <= 1'b1;
						state <= trailer;
					end
					trailer: state <= skip; // sequence word ignored
					default: state <= state;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wordBus.wordValid)
		begin
			fifoWord.isCommand <= (state == escaped) && escCmd;
			fifoWord.data      <= wordBus.word;
		end
	end

endmodule

`default_nettype wire

//--- rtl/spiWordReceiver.sv
`timescale 1ns/100ps
`default_nettype none

module spiWordReceiver import spiProtoPkg::*; (
	input  logic  clk,
	input  logic  rstN,
	input  logic  spiSclk,
	input  logic  spiMosi,
	input  logic  spiCsN,
	spiWordIf.src wordBus
);

	localparam int cntBits = $clog2(spiWordBits);

	logic [1:0]             sclkSync;
	logic [1:0]             mosiSync;
	logic [1:0]             csSync;
	logic                   sclkPrev;
	logic                   csPrev;
	logic [cntBits-1:0]     bitCnt;
	logic [spiWordBits-2:0] shiftReg;
	logic                   sclkRise;
	logic                   lastBit;

	assign sclkRise = sclkSync[1] & ~sclkPrev & ~csSync[1];
	assign lastBit  = (bitCnt == cntBits'(spiWordBits - 1));

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			sclkSync           <= '0;
			csSync             <= '1; // bus idle, csN high
			sclkPrev           <= 1'b0;
			csPrev             <= 1'b1;
			bitCnt             <= '0;
			wordBus.wordValid  <= 1'b0;
			wordBus.frameStart <= 1'b0;
			wordBus.frameEnd   <= 1'b0;
		end
		else
		begin
			sclkSync           <= {sclkSync[0], spiSclk};
			csSync             <= {csSync[0], spiCsN};
			sclkPrev           <= sclkSync[1];
			csPrev             <= csSync[1];
			wordBus.frameStart <= csPrev & ~csSync[1];
			wordBus.frameEnd   <= ~csPrev & csSync[1];
			wordBus.wordValid  <= sclkRise & lastBit; // 3 clk after the 16th edge
			if (csSync[1])
				bitCnt <= '0;
			else if (sclkRise)
				bitCnt <= bitCnt + 1'b1; // wraps to 0 after a full word
		end
	end

	always_ff @(posedge clk)
	begin
		mosiSync <= {mosiSync[0], spiMosi};
		if (sclkRise)
		begin
			shiftReg <= {shiftReg[spiWordBits-3:0], mosiSync[1]}; // msb first
			if (lastBit)
				wordBus.word <= {shiftReg, mosiSync[1]};
		end
	end

endmodule

`default_nettype wire

//--- rtl/spiWordIf.sv
`timescale 1ns/100ps
`default_nettype none

interface spiWordIf import spiProtoPkg::*; ();

	logic [spiWordBits-1:0] word;
	logic                   wordValid;  // one clk per assembled word
	logic                   frameStart; // csN fell
	logic                   frameEnd;   // csN rose

	modport src (output word, wordValid, frameStart, frameEnd);
	modport dst (input word, wordValid, frameStart, frameEnd);

endinterface

`default_nettype wire

//--- rtl/spiProtoPkg.sv
`default_nettype none

package spiProtoPkg;

	localparam int          spiWordBits = 16;
	localparam logic [7:0]  cmdSendMil  = 8'hA2;
	localparam logic [15:0] escCommand  = 16'hFFA1; // next word is a 1553 command
	localparam logic [15:0] escData     = 16'hFFA3; // next word is literal data
	localparam logic [7:0]  hdrReserved = 8'h00;

	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] reserved;
	} addrWord_t;

	typedef struct packed {
		logic [7:0] count; // payload words
		logic [7:0] cmd;
	} sizeCmdWord_t;

endpackage

`default_nettype wire

//--- rtl/milStd1553Pkg.sv
`default_nettype none

package milStd1553Pkg;

	localparam int milDataBits     = 16;
	localparam int milSyncHalfBits = 3; // each sync half is 1.5 bit times
	localparam int milGapBits      = 4; // idle bit times between words
	localparam int milWordHalves   = 2 * milSyncHalfBits + 2 * (milDataBits + 1);

	// transmit payload
	typedef struct packed {
		logic                   isCommand;
		logic [milDataBits-1:0] data;
	} milWord_t;

	// receive payload
	typedef struct packed {
		logic                   isCommand;
		logic [milDataBits-1:0] data;
		logic                   parityErr;
	} milRxWord_t;

endpackage

`default_nettype wire
